// File: project.f
+incdir+source
source/icache_pkg.sv
source/icache_array.sv
source/prefetch_queue.sv
source/fetch_merge.sv
source/icache_top.sv
test/wb_memory_model.sv
test/icache_tb.sv

// File: source/fetch_merge.sv
`include "icache_consts.svh"

module fetch_merge import icache_pkg::*; (
  input fetch_addr_t fetch_addr,
  input logic fetch_request,
  input lookup_t lookup,
  input refill_t refill,
  output logic [`ICACHE_DATA_BITS-1:0] fetch_data,
  output logic fetch_valid,
  output array_write_t write
);

  logic refill_match;

  // Byte offset is ignored, both sides name whole words
  assign refill_match = refill.valid
                        && (refill.addr.tag == fetch_addr.tag)
                        && (refill.addr.index == fetch_addr.index);

  assign fetch_valid = fetch_request && (lookup.hit || refill_match);

  // Bypass the bus word while the array still misses
  assign fetch_data = lookup.hit ? lookup.data : refill.data;

  // Every returning word is installed, prefetched ones too
  assign write = '{
    enable: refill.valid,
    addr: refill.addr,
    data: refill.data
  };

endmodule

// File: source/icache_array.sv
`include "icache_consts.svh"

module icache_array import icache_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_addr_t lookup_addr,
  output lookup_t lookup,
  input array_write_t write
);

  array_entry_t entries [`ICACHE_SETS];
  array_entry_t selected;

  // Lookup is combinational so a hit answers in the request cycle
  assign selected = entries[lookup_addr.index];
  assign lookup.hit = selected.valid && (selected.tag == lookup_addr.tag);
  assign lookup.data = selected.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ICACHE_SETS; i++) begin
        entries[i].valid <= 1'b0;  // Tags and data keep their contents
      end
    end else if (write.enable) begin
      // Refill replaces whatever lived at this index
      entries[write.addr.index] <= '{
        valid: 1'b1,
        tag: write.addr.tag,
        data: write.data
      };
    end
  end

endmodule

// File: source/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Fetch and bus address width
`define ICACHE_ADDR_BITS 32

// One instruction word
`define ICACHE_DATA_BITS 64

// Direct-mapped, one word per set
`define ICACHE_SETS 32

`define ICACHE_QUEUE_DEPTH 4  // Prefetch address slots

`endif

// File: source/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

  localparam int OFFSET_BITS = $clog2(`ICACHE_DATA_BITS / 8);
  localparam int INDEX_BITS = $clog2(`ICACHE_SETS);
  localparam int TAG_BITS = `ICACHE_ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [INDEX_BITS-1:0] index;
    logic [OFFSET_BITS-1:0] offset;  // Byte within the word
  } fetch_addr_t;

  typedef struct packed {
    logic valid;
    logic [TAG_BITS-1:0] tag;
    logic [`ICACHE_DATA_BITS-1:0] data;
  } array_entry_t;

  typedef struct packed {
    logic hit;
    logic [`ICACHE_DATA_BITS-1:0] data;
  } lookup_t;

  typedef struct packed {
    logic valid;  // Only in the ack cycle
    fetch_addr_t addr;
    logic [`ICACHE_DATA_BITS-1:0] data;
  } refill_t;

  typedef struct packed {
    logic enable;
    fetch_addr_t addr;
    logic [`ICACHE_DATA_BITS-1:0] data;
  } array_write_t;

  // Master side of a Wishbone classic read, we is tied off at the top
  typedef struct packed {
    logic cyc;
    logic stb;
    logic [`ICACHE_ADDR_BITS-1:0] adr;
  } wb_request_t;

  typedef struct packed {
    logic ack;
    logic [`ICACHE_DATA_BITS-1:0] dat;
  } wb_response_t;

endpackage

// File: source/icache_top.sv
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_addr_t fetch_addr,
  input logic fetch_request,
  output logic [`ICACHE_DATA_BITS-1:0] fetch_data,
  output logic fetch_valid,
  output wb_request_t wb_request,
  output logic wb_we,
  input wb_response_t wb_response
);

  lookup_t lookup;
  refill_t refill;
  array_write_t array_write;

  assign wb_we = 1'b0;  // Read-only master

  icache_array array_i (
    .clock(clock),
    .reset(reset),
    .lookup_addr(fetch_addr),
    .lookup(lookup),
    .write(array_write)
  );

  prefetch_queue queue_i (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .fetch_request(fetch_request),
    .lookup_hit(lookup.hit),
    .wb_request(wb_request),
    .wb_response(wb_response),
    .refill(refill)
  );

  fetch_merge merge_i (
    .fetch_addr(fetch_addr),
    .fetch_request(fetch_request),
    .lookup(lookup),
    .refill(refill),
    .fetch_data(fetch_data),
    .fetch_valid(fetch_valid),
    .write(array_write)
  );

endmodule

// File: source/prefetch_queue.sv
`include "icache_consts.svh"

module prefetch_queue import icache_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_addr_t fetch_addr,
  input logic fetch_request,
  input logic lookup_hit,
  output wb_request_t wb_request,
  input wb_response_t wb_response,
  output refill_t refill
);

  localparam int SLOT_BITS = $clog2(`ICACHE_QUEUE_DEPTH);
  localparam int COUNT_BITS = $clog2(`ICACHE_QUEUE_DEPTH + 1);

  fetch_addr_t queue [`ICACHE_QUEUE_DEPTH];
  fetch_addr_t queue_next [`ICACHE_QUEUE_DEPTH];
  logic [COUNT_BITS-1:0] count;
  logic [COUNT_BITS-1:0] count_next;
  logic [SLOT_BITS-1:0] tail_slot;

  fetch_addr_t fetch_word;
  fetch_addr_t next_word;
  logic [`ICACHE_QUEUE_DEPTH-1:0] queued_match;
  logic head_match;
  logic bus_done;
  logic bus_free;
  logic reload;
  logic append;

  assign fetch_word = '{tag: fetch_addr.tag, index: fetch_addr.index, offset: '0};
  assign next_word = fetch_addr_t'(fetch_word + `ICACHE_ADDR_BITS'(8));

  // Parallel compare of the next word against every occupied slot
  always_comb begin
    for (int i = 0; i < `ICACHE_QUEUE_DEPTH; i++) begin
      queued_match[i] = (i < count) && (queue[i] == next_word);
    end
  end

  assign head_match = (count != '0) && (queue[0] == fetch_word);

  assign bus_done = wb_request.cyc && wb_response.ack;
  assign bus_free = !wb_request.cyc || wb_response.ack;  // Classic reads cannot be aborted

  // Restart the stream on a miss, unless the head is already that word
  assign reload = fetch_request && !lookup_hit && !head_match && bus_free;

  always_comb begin
    queue_next = queue;
    count_next = count;

    if (bus_done) begin
      for (int i = 0; i < `ICACHE_QUEUE_DEPTH - 1; i++) begin
        queue_next[i] = queue[i + 1];
      end
      count_next = count - 1'b1;
    end

    tail_slot = count_next[SLOT_BITS-1:0];
    // Only an active stream is extended, an idle queue stays idle on hits
    append = fetch_request && (count != '0) && !(|queued_match)
             && (count_next < `ICACHE_QUEUE_DEPTH);

    if (reload) begin
      queue_next[0] = fetch_word;
      queue_next[1] = next_word;
      count_next = COUNT_BITS'(2);
    end else if (append) begin
      queue_next[tail_slot] = next_word;
      count_next = count_next + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    queue <= queue_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      wb_request <= '0;
    end else begin
      count <= count_next;
      if (bus_done) begin
        wb_request.cyc <= 1'b0;  // Forces one idle cycle between reads
        wb_request.stb <= 1'b0;
      end else if (!wb_request.cyc && (count_next != '0)) begin
        wb_request.cyc <= 1'b1;
        wb_request.stb <= 1'b1;
        wb_request.adr <= queue_next[0];  // Held until ack
      end
    end
  end

  assign refill = '{
    valid: bus_done,
    addr: fetch_addr_t'(wb_request.adr),
    data: wb_response.dat
  };

endmodule

// File: test/icache_tb.sv
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_FETCHES = 200;

  logic clock;
  logic reset;
  fetch_addr_t fetch_addr;
  logic fetch_request;
  logic [`ICACHE_DATA_BITS-1:0] fetch_data;
  logic fetch_valid;
  wb_request_t wb_request;
  logic wb_we;
  wb_response_t wb_response;

  logic [`ICACHE_ADDR_BITS-1:0] read_log [$];  // Bus read addresses in issue order
  logic [15:0] lfsr;

  icache_top dut_i (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .fetch_request(fetch_request),
    .fetch_data(fetch_data),
    .fetch_valid(fetch_valid),
    .wb_request(wb_request),
    .wb_we(wb_we),
    .wb_response(wb_response)
  );

  wb_memory_model memory_i (
    .clock(clock),
    .reset(reset),
    .wb_request(wb_request),
    .wb_response(wb_response)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Expected memory content for a word address
  function automatic logic [`ICACHE_DATA_BITS-1:0] expected_word(
    input logic [`ICACHE_ADDR_BITS-1:0] addr
  );
    return {~addr, addr};
  endfunction

  function automatic int reads_at(input logic [`ICACHE_ADDR_BITS-1:0] addr, input int from);
    int hits;
    hits = 0;
    for (int i = from; i < read_log.size(); i++) begin
      if (read_log[i] == addr) hits++;
    end
    return hits;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_fetch(input logic [`ICACHE_DATA_BITS-1:0] actual, expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: fetch_data is %h, expected %h",
                                  $time, actual, expected));
    end
  endtask

  task automatic check_bus(input wb_request_t actual, input wb_request_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf(
        "mismatch at %0t: wb_request is cyc %b stb %b adr %h, expected cyc %b stb %b adr %h",
        $time, actual.cyc, actual.stb, actual.adr, expected.cyc, expected.stb, expected.adr));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      stop_with_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic fetch_and_wait(input logic [`ICACHE_ADDR_BITS-1:0] addr, output int latency);
    int cycles;
    @(posedge clock);
    fetch_addr <= fetch_addr_t'(addr);
    fetch_request <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!fetch_valid && cycles < TIMEOUT_CYCLES);
    if (!fetch_valid) begin
      stop_with_failure($sformatf("fetch of address %h got no fetch_valid in %0d cycles",
                                  addr, TIMEOUT_CYCLES));
    end
    latency = cycles - 1;  // Valid at the first sample means zero latency
    @(posedge clock);
    fetch_request <= 1'b0;
  endtask

  // Idle means cyc low long enough that the queue must be empty
  task automatic wait_bus_idle();
    int cycles;
    int quiet;
    cycles = 0;
    quiet = 0;
    while (quiet < 3 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clock);
      cycles++;
      quiet = wb_request.cyc ? 0 : quiet + 1;
    end
    if (quiet < 3) stop_with_failure("the bus did not go idle within 200 cycles");
  endtask

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin : compare
    logic cyc_seen;
    logic ack_seen;
    logic reset_seen;
    logic [`ICACHE_ADDR_BITS-1:0] held_adr;
    cyc_seen = 1'b0;
    ack_seen = 1'b0;
    reset_seen = 1'b1;
    held_adr = '0;
    forever begin
      @(negedge clock);
      check_flag("wb_we", wb_we, 1'b0);
      if (reset || reset_seen) begin
        check_bus(wb_request, '{cyc: 1'b0, stb: 1'b0, adr: wb_request.adr});
        check_flag("fetch_valid", fetch_valid, 1'b0);
      end else begin
        if (fetch_valid) begin
          check_fetch(fetch_data, expected_word(fetch_addr));
        end
        if (ack_seen) begin
          check_bus(wb_request, '{cyc: 1'b0, stb: 1'b0, adr: wb_request.adr});  // Idle gap
        end else if (wb_request.cyc && !cyc_seen) begin
          held_adr = wb_request.adr;
          read_log.push_back(held_adr);
          check_bus(wb_request, '{cyc: 1'b1, stb: 1'b1, adr: held_adr & ~32'h7});
        end else if (wb_request.cyc) begin
          check_bus(wb_request, '{cyc: 1'b1, stb: 1'b1, adr: held_adr});
        end
      end
      reset_seen = reset;
      cyc_seen = wb_request.cyc;
      ack_seen = wb_request.cyc && wb_response.ack;
    end
  end

  initial begin : drive
    int latency;
    int start;
    logic [`ICACHE_ADDR_BITS-1:0] addr;
    logic [7:0] word;
    reset = 1'b1;
    fetch_addr = '0;
    fetch_request = 1'b0;
    lfsr = 16'd5353;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // Cold miss, then the prefetched next word
    start = read_log.size();
    fetch_and_wait(32'h0000_2000, latency);
    if (read_log.size() <= start || read_log[start] != 32'h0000_2000) begin
      stop_with_failure("the first bus read after a cold miss was not at the fetch address");
    end
    check_count("reads at 00002000", reads_at(32'h0000_2000, start), 1);
    wait_bus_idle();
    start = read_log.size();
    fetch_and_wait(32'h0000_2008, latency);
    wait_bus_idle();
    check_count("reads at 00002008", reads_at(32'h0000_2008, start), 0);

    // Zero-latency hit
    start = read_log.size();
    fetch_and_wait(32'h0000_2000, latency);
    check_count("hit latency", latency, 0);
    wait_bus_idle();
    check_count("bus reads on hit", read_log.size() - start, 0);

    // Same index, different tags
    for (int i = 0; i < 4; i++) begin
      addr = i[0] ? 32'h0005_3040 : 32'h0000_3040;
      start = read_log.size();
      fetch_and_wait(addr, latency);
      check_count($sformatf("reads at %h", addr), reads_at(addr, start), 1);
    end

    for (int n = 0; n < RANDOM_FETCHES; n++) begin
      for (int b = 0; b < 8; b++) begin
        lfsr = lfsr_step(lfsr);
        word[b] = lfsr[0];
      end
      addr = 32'h0004_0000 + {21'd0, word, 3'b000};
      fetch_and_wait(addr, latency);
    end
    wait_bus_idle();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: test/wb_memory_model.sv
`include "icache_consts.svh"

module wb_memory_model import icache_pkg::*; (
  input logic clock,
  input logic reset,
  input wb_request_t wb_request,
  output wb_response_t wb_response
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [15:0] lfsr;
  logic waiting;
  logic [1:0] wait_left;

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Inverted address above the address itself
  function automatic logic [`ICACHE_DATA_BITS-1:0] memory_word(
    input logic [`ICACHE_ADDR_BITS-1:0] addr
  );
    return {~addr, addr};
  endfunction

  always @(posedge clock) begin : respond
    logic [1:0] delay;
    if (reset) begin
      lfsr = 16'd5353;
      wb_response <= '0;
      waiting <= 1'b0;
      wait_left <= '0;
    end else if (wb_response.ack) begin
      wb_response.ack <= 1'b0;  // Ack lasts one cycle
    end else if (wb_request.cyc && wb_request.stb) begin
      if (!waiting) begin
        for (int i = 0; i < 2; i++) begin
          lfsr = lfsr_step(lfsr);
          delay[i] = lfsr[0];
        end
        if (delay == 2'd0) begin
          wb_response.ack <= 1'b1;
          wb_response.dat <= memory_word(wb_request.adr);
        end else begin
          waiting <= 1'b1;
          wait_left <= delay - 2'd1;
        end
      end else if (wait_left == 2'd0) begin
        wb_response.ack <= 1'b1;
        wb_response.dat <= memory_word(wb_request.adr);
        waiting <= 1'b0;
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

endmodule
